// ==== sim.f ====
+incdir+.
regex_pkg.sv
arbiter_2_fixed.sv
arbiter_rr_n.sv
instr_memory.sv
engine_and_station_xy.sv
topology_mesh.sv
regex_top.sv
tb_regex_top.sv

// ==== tb_regex_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "regex_cfg.svh"

module tb_regex_top;

    localparam int N_SINGLE   = 4;
    localparam int N_PROGS    = 20;
    localparam int STR_LEN    = 16;
    // every string runs STR_LEN characters plus one flush step
    localparam int MAX_CYCLES = (N_PROGS + 2 * N_SINGLE) * (STR_LEN + 1) * 200 + 2000;

    logic                             clk;
    logic                             rst_n;
    logic [`REGEX_CHAR_WIDTH-1:0]     cur_cc;
    logic                             cur_is_even_character;
    logic                             enable;
    logic                             override_valid;
    regex_pkg::token_t                override_data;
    logic                             override_ready;
    logic                             mem_cc_valid;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_cc_addr;
    logic                             mem_cc_ready;
    logic [`REGEX_MEM_WIDTH-1:0]      mem_cc_data;
    logic                             wr_en;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] wr_addr;
    logic [`REGEX_MEM_WIDTH-1:0]      wr_data;
    logic                             any_bb_accept;
    logic                             any_bb_running;
    logic                             all_bb_full;

    logic [31:0]       lfsr = 32'hd391_392d;
    int                n_checks = 0;
    int                n_errors = 0;
    int                cycles = 0;
    regex_pkg::instr_u prog [16];
    int                prog_len;
    logic [7:0]        str [STR_LEN];
    // live model threads, one bit per pc
    logic [15:0]       threads;

    regex_top dut0 (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cur_cc                (cur_cc),
        .cur_is_even_character (cur_is_even_character),
        .enable                (enable),
        .override_valid        (override_valid),
        .override_data         (override_data),
        .override_ready        (override_ready),
        .mem_cc_valid          (mem_cc_valid),
        .mem_cc_addr           (mem_cc_addr),
        .mem_cc_ready          (mem_cc_ready),
        .mem_cc_data           (mem_cc_data),
        .wr_en                 (wr_en),
        .wr_addr               (wr_addr),
        .wr_data               (wr_data),
        .any_bb_accept         (any_bb_accept),
        .any_bb_running        (any_bb_running),
        .all_bb_full           (all_bb_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run still busy after %0d cycles, errors so far %0d",
                     cycles, n_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // alphabet is a..d
    function automatic logic [7:0] letter(input int idx);
        return 8'h61 + 8'(idx);
    endfunction

    function automatic regex_pkg::instr_u make_instr(input regex_pkg::opcode_e op,
                                                     input logic [7:0] low);
        regex_pkg::instr_u w;
        w = '0;
        if (op == regex_pkg::MATCH_CHAR)
        begin
            w.ch.op = op;
            w.ch.cc = low;
        end
        else
        begin
            w.tgt.op     = op;
            w.tgt.target = low;
        end
        return w;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp)
        else
        begin
            n_errors++;
            $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        n_checks++;
        assert (cond)
        else
        begin
            n_errors++;
            $display("error at %0t ns: %s", $time, what);
        end
    endtask

    // host read through mem_cc, data one cycle after the grant
    task automatic read_word(input logic [7:0] addr, input logic [15:0] exp,
                             input int max_wait);
        int waited;
        waited       = 0;
        mem_cc_valid = 1'b1;
        mem_cc_addr  = addr;
        @(negedge clk);
        while (!mem_cc_ready)
        begin
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        mem_cc_valid = 1'b0;
        @(negedge clk);
        check_true(waited <= max_wait,
                   $sformatf("host read of %0h waited %0d cycles for a grant", addr, waited));
        check_equal("mem_cc_data", mem_cc_data, exp);
        @(posedge clk);
        #1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++)
        begin
            wr_en   = 1'b1;
            wr_addr = 8'(i);
            wr_data = prog[i];
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        // nothing else requests memory now, so no wait allowed
        for (int i = 0; i < prog_len; i++)
            read_word(8'(i), prog[i], 0);
    endtask

    // at most one SPLIT keeps live threads well below the queue depth
    task automatic build_program();
        int len;
        int n_split;
        int op_sel;
        int tgt;
        len     = 3 + int'(take_bits(2));
        n_split = 0;
        for (int pc = 0; pc < len - 1; pc++)
        begin
            op_sel = int'(take_bits(2));
            tgt    = pc + 1 + int'(take_bits(3) % (len - 1 - pc));
            if (op_sel == 2 && n_split == 0)
            begin
                prog[pc] = make_instr(regex_pkg::SPLIT, 8'(tgt));
                n_split++;
            end
            else if (op_sel == 3)
                prog[pc] = make_instr(regex_pkg::JUMP, 8'(tgt));
            else
                prog[pc] = make_instr(regex_pkg::MATCH_CHAR, letter(int'(take_bits(2))));
        end
        prog[len-1] = make_instr(regex_pkg::ACCEPT, 8'h00);
        prog_len    = len;
    endtask

    // nfa set step: closure over SPLIT/JUMP, then consume ch
    task automatic model_step(input logic [7:0] ch, output bit acc);
        logic [15:0]       cl;
        logic [15:0]       nx;
        regex_pkg::instr_u w;
        cl  = threads | 16'h0001;
        nx  = '0;
        acc = 1'b0;
        for (int pc = 0; pc < prog_len; pc++)
        begin
            if (cl[pc])
            begin
                w = prog[pc];
                case (w.ch.op)
                    regex_pkg::MATCH_CHAR:
                        if (w.ch.cc == ch)
                            nx[pc+1] = 1'b1;
                    regex_pkg::SPLIT:
                    begin
                        cl[pc+1]         = 1'b1;
                        cl[w.tgt.target] = 1'b1;
                    end
                    regex_pkg::JUMP:
                        cl[w.tgt.target] = 1'b1;
                    default:
                        acc = 1'b1;
                endcase
            end
        end
        threads = nx;
    endtask

    task automatic inject(input logic par);
        override_valid      = 1'b1;
        override_data.parity = par;
        override_data.pc     = '0;
        @(negedge clk);
        while (!override_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        override_valid = 1'b0;
    endtask

    // one character: inject pc 0, then wait for the mesh to go quiet
    task automatic run_step(input logic [7:0] ch, input logic par, output bit got);
        bit done;
        cur_cc                = ch;
        cur_is_even_character = par;
        inject(par);
        got  = 1'b0;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            if (any_bb_accept)
                got = 1'b1;
            check_equal("all_bb_full", all_bb_full, 0);
            if (!any_bb_running)
                done = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_string(output bit hw_any, output bit model_any);
        logic       par;
        logic [7:0] ch;
        logic [7:0] addr;
        bit         exp_acc;
        bit         got;
        threads   = '0;
        par       = 1'b1;
        hw_any    = 1'b0;
        model_any = 1'b0;
        for (int i = 0; i <= STR_LEN; i++)
        begin
            // the extra step uses a character outside the alphabet
            ch   = (i < STR_LEN) ? str[i] : 8'h00;
            addr = 8'(take_bits(3) % prog_len);
            model_step(ch, exp_acc);
            fork
                run_step(ch, par, got);
                read_word(addr, prog[addr], 4);
            join
            check_equal("any_bb_accept", got, exp_acc);
            hw_any    = hw_any | got;
            model_any = model_any | exp_acc;
            par       = !par;
        end
        check_equal("accept outcome", hw_any, model_any);
    endtask

    initial
    begin
        int         cidx;
        int         pos;
        bit         hw_any;
        bit         model_any;
        rst_n                 = 1'b0;
        enable                = 1'b0;
        cur_cc                = '0;
        cur_is_even_character = 1'b1;
        override_valid        = 1'b0;
        override_data         = '0;
        mem_cc_valid          = 1'b0;
        mem_cc_addr           = '0;
        wr_en                 = 1'b0;
        wr_addr               = '0;
        wr_data               = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        enable = 1'b1;
        @(negedge clk);
        check_equal("any_bb_accept", any_bb_accept, 0);
        check_equal("any_bb_running", any_bb_running, 0);
        check_equal("all_bb_full", all_bb_full, 0);
        check_equal("override_ready", override_ready, 0);
        check_equal("mem_cc_ready", mem_cc_ready, 0);
        @(posedge clk);
        #1;

        // single character programs, with and without that character
        for (int p = 0; p < N_SINGLE; p++)
        begin
            cidx     = int'(take_bits(2));
            prog[0]  = make_instr(regex_pkg::MATCH_CHAR, letter(cidx));
            prog[1]  = make_instr(regex_pkg::ACCEPT, 8'h00);
            prog_len = 2;
            load_program();
            for (int i = 0; i < STR_LEN; i++)
                str[i] = letter(int'(take_bits(2)));
            pos      = int'(take_bits(4));
            str[pos] = letter(cidx);
            run_string(hw_any, model_any);
            check_equal("any_bb_accept on string with match", hw_any, 1);
            for (int i = 0; i < STR_LEN; i++)
                str[i] = letter((cidx + 1 + int'(take_bits(2) % 3)) % 4);
            run_string(hw_any, model_any);
            check_equal("any_bb_accept on string without match", hw_any, 0);
        end

        for (int p = 0; p < N_PROGS; p++)
        begin
            build_program();
            load_program();
            for (int i = 0; i < STR_LEN; i++)
                str[i] = letter(int'(take_bits(2)));
            run_string(hw_any, model_any);
        end

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== regex_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "regex_cfg.svh"

module regex_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire [`REGEX_CHAR_WIDTH-1:0]      cur_cc,
    input  wire                              cur_is_even_character,
    input  wire                              enable,
    input  wire                              override_valid,
    input  wire regex_pkg::token_t           override_data,
    output logic                             override_ready,
    input  wire                              mem_cc_valid,
    input  wire [`REGEX_MEM_ADDR_WIDTH-1:0]  mem_cc_addr,
    output logic                             mem_cc_ready,
    output logic [`REGEX_MEM_WIDTH-1:0]      mem_cc_data,
    input  wire                              wr_en,
    input  wire [`REGEX_MEM_ADDR_WIDTH-1:0]  wr_addr,
    input  wire [`REGEX_MEM_WIDTH-1:0]       wr_data,
    output logic                             any_bb_accept,
    output logic                             any_bb_running,
    output logic                             all_bb_full
);

    logic                             mem_valid;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr;
    logic                             mem_ready;
    logic [`REGEX_MEM_WIDTH-1:0]      mem_rd_data;

    topology_mesh mesh_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cur_cc                (cur_cc),
        .cur_is_even_character (cur_is_even_character),
        .enable                (enable),
        .override_valid        (override_valid),
        .override_data         (override_data),
        .override_ready        (override_ready),
        .mem_valid             (mem_valid),
        .mem_addr              (mem_addr),
        .mem_ready             (mem_ready),
        .mem_rd_data           (mem_rd_data),
        .mem_cc_valid          (mem_cc_valid),
        .mem_cc_addr           (mem_cc_addr),
        .mem_cc_ready          (mem_cc_ready),
        .mem_cc_data           (mem_cc_data),
        .any_bb_accept         (any_bb_accept),
        .any_bb_running        (any_bb_running),
        .all_bb_full           (all_bb_full)
    );

    // program store, loaded by the host
    instr_memory memory_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_valid (mem_valid),
        .rd_addr  (mem_addr),
        .rd_ready (mem_ready),
        .rd_data  (mem_rd_data)
    );

endmodule

`default_nettype wire

// ==== topology_mesh.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "regex_cfg.svh"

module topology_mesh (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire [`REGEX_CHAR_WIDTH-1:0]      cur_cc,
    input  wire                              cur_is_even_character,
    input  wire                              enable,
    input  wire                              override_valid,
    input  wire regex_pkg::token_t           override_data,
    output logic                             override_ready,
    output logic                             mem_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr,
    input  wire                              mem_ready,
    input  wire [`REGEX_MEM_WIDTH-1:0]       mem_rd_data,
    input  wire                              mem_cc_valid,
    input  wire [`REGEX_MEM_ADDR_WIDTH-1:0]  mem_cc_addr,
    output logic                             mem_cc_ready,
    output logic [`REGEX_MEM_WIDTH-1:0]      mem_cc_data,
    output logic                             any_bb_accept,
    output logic                             any_bb_running,
    output logic                             all_bb_full
);

    localparam int NX = `REGEX_BB_N_X;
    localparam int NY = `REGEX_BB_N_Y;
    localparam int NB = NX * NY;

    // column NX of x and row NY of y are the wrap-around ends
    wire                    cx_valid [NY][NX+1];
    wire                    cx_ready [NY][NX+1];
    wire regex_pkg::token_t cx_data  [NY][NX+1];
    wire                    cy_valid [NY+1][NX];
    wire                    cy_ready [NY+1][NX];
    wire regex_pkg::token_t cy_data  [NY+1][NX];

    // requesters 0..NB-1 are engines, NB is the host read port
    wire                             rq_valid [NB+1];
    wire                             rq_ready [NB+1];
    wire [`REGEX_MEM_ADDR_WIDTH-1:0] rq_addr  [NB+1];

    wire [NB-1:0] bb_accepts;
    wire [NB-1:0] bb_running;
    wire [NB-1:0] bb_full;

    for (genvar y = 0; y < NY; y++)
    begin : g_row
        for (genvar x = 0; x < NX; x++)
        begin : g_col
            engine_and_station_xy engine_i (
                .clk                   (clk),
                .rst_n                 (rst_n),
                .cur_cc                (cur_cc),
                .cur_is_even_character (cur_is_even_character),
                .enable                (enable),
                .x_in_valid            (cx_valid[y][x]),
                .x_in_data             (cx_data[y][x]),
                .x_in_ready            (cx_ready[y][x]),
                .y_in_valid            (cy_valid[y][x]),
                .y_in_data             (cy_data[y][x]),
                .y_in_ready            (cy_ready[y][x]),
                .x_out_valid           (cx_valid[y][x+1]),
                .x_out_data            (cx_data[y][x+1]),
                .x_out_ready           (cx_ready[y][x+1]),
                .y_out_valid           (cy_valid[y+1][x]),
                .y_out_data            (cy_data[y+1][x]),
                .y_out_ready           (cy_ready[y+1][x]),
                .mem_valid             (rq_valid[y*NX+x]),
                .mem_addr              (rq_addr[y*NX+x]),
                .mem_ready             (rq_ready[y*NX+x]),
                .mem_data              (mem_rd_data),
                .bb_accepts            (bb_accepts[y*NX+x]),
                .bb_running            (bb_running[y*NX+x]),
                .bb_full               (bb_full[y*NX+x])
            );
        end
    end

    // row 0 wrap shares the entry with host injection
    arbiter_2_fixed override_arb (
        .in_0_valid (override_valid),
        .in_0_data  (override_data),
        .in_0_ready (override_ready),
        .in_1_valid (cx_valid[0][NX]),
        .in_1_data  (cx_data[0][NX]),
        .in_1_ready (cx_ready[0][NX]),
        .out_valid  (cx_valid[0][0]),
        .out_data   (cx_data[0][0]),
        .out_ready  (cx_ready[0][0])
    );

    // other rows wrap directly
    for (genvar y = 1; y < NY; y++)
    begin : g_x_wrap
        assign cx_valid[y][0]  = cx_valid[y][NX];
        assign cx_data[y][0]   = cx_data[y][NX];
        assign cx_ready[y][NX] = cx_ready[y][0];
    end

    // columns wrap bottom to top
    for (genvar x = 0; x < NX; x++)
    begin : g_y_wrap
        assign cy_valid[0][x]  = cy_valid[NY][x];
        assign cy_data[0][x]   = cy_data[NY][x];
        assign cy_ready[NY][x] = cy_ready[0][x];
    end

    assign rq_valid[NB] = mem_cc_valid;
    assign rq_addr[NB]  = mem_cc_addr;
    assign mem_cc_ready = rq_ready[NB];

    arbiter_rr_n #(
        .N      (NB + 1),
        .DWIDTH (`REGEX_MEM_ADDR_WIDTH)
    ) mem_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rq_valid),
        .in_data   (rq_addr),
        .in_ready  (rq_ready),
        .out_valid (mem_valid),
        .out_data  (mem_addr),
        .out_ready (mem_ready)
    );

    // read data goes to everyone, the granted requester takes it
    assign mem_cc_data = mem_rd_data;

    assign any_bb_accept  = |bb_accepts;
    assign any_bb_running = |bb_running;
    assign all_bb_full    = &bb_full;

endmodule

`default_nettype wire

// ==== engine_and_station_xy.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "regex_cfg.svh"

module engine_and_station_xy (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [`REGEX_CHAR_WIDTH-1:0]     cur_cc,
    input  wire                             cur_is_even_character,
    input  wire                             enable,
    input  wire                             x_in_valid,
    input  wire regex_pkg::token_t          x_in_data,
    output logic                            x_in_ready,
    input  wire                             y_in_valid,
    input  wire regex_pkg::token_t          y_in_data,
    output logic                            y_in_ready,
    output logic                            x_out_valid,
    output regex_pkg::token_t               x_out_data,
    input  wire                             x_out_ready,
    output logic                            y_out_valid,
    output regex_pkg::token_t               y_out_data,
    input  wire                             y_out_ready,
    output logic                            mem_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr,
    input  wire                             mem_ready,
    input  wire [`REGEX_MEM_WIDTH-1:0]      mem_data,
    output logic                            bb_accepts,
    output logic                            bb_running,
    output logic                            bb_full
);

    localparam int IDX_W = `REGEX_FIFO_DEPTH_BITS;
    localparam int DEPTH = 1 << IDX_W;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;

    regex_pkg::token_t slot_tok [DEPTH];
    logic [DEPTH-1:0]  slot_valid;
    logic [IDX_W-1:0]  free_idx;
    logic [IDX_W-1:0]  pop_idx;
    logic              has_free;
    logic              has_cur;
    logic              push;
    logic              pop;
    regex_pkg::token_t push_tok;
    logic [1:0]        state;
    regex_pkg::token_t cur_tok;
    regex_pkg::instr_u instr;

    // station: slots rather than a strict fifo, so
    // tokens of the other parity can be skipped
    always_comb
    begin
        has_free = 1'b0;
        has_cur  = 1'b0;
        free_idx = '0;
        pop_idx  = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!slot_valid[i] && !has_free)
            begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);
            end
            if (slot_valid[i] && !has_cur &&
                slot_tok[i].parity == cur_is_even_character)
            begin
                has_cur = 1'b1;
                pop_idx = IDX_W'(i);
            end
        end
    end

    // one push per cycle, x before y
    assign x_in_ready = has_free;
    assign y_in_ready = has_free && !x_in_valid;
    assign push       = (x_in_valid || y_in_valid) && has_free;
    assign push_tok   = x_in_valid ? x_in_data : y_in_data;
    assign bb_full    = !has_free;

    // next thread only once both outputs are drained
    assign pop = (state == S_IDLE) && enable && has_cur && !x_out_valid && !y_out_valid;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            slot_valid <= '0;
        else
        begin
            if (push)
                slot_valid[free_idx] <= 1'b1;
            if (pop)
                slot_valid[pop_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            slot_tok[free_idx] <= push_tok;
        if (pop)
            cur_tok <= slot_tok[pop_idx];
    end

    // fetch
    assign mem_valid = (state == S_REQ);
    assign mem_addr  = cur_tok.pc;
    assign instr     = mem_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= S_IDLE;
            x_out_valid <= 1'b0;
            y_out_valid <= 1'b0;
            bb_accepts  <= 1'b0;
        end
        else
        begin
            bb_accepts <= 1'b0;
            if (x_out_valid && x_out_ready)
                x_out_valid <= 1'b0;
            if (y_out_valid && y_out_ready)
                y_out_valid <= 1'b0;
            case (state)
                S_IDLE:
                    if (pop)
                        state <= S_REQ;
                S_REQ:
                    if (mem_ready)
                        state <= S_DATA;
                S_DATA:
                begin
                    // word arrives this cycle, execute it
                    state <= S_IDLE;
                    case (instr.ch.op)
                        regex_pkg::MATCH_CHAR:
                            if (instr.ch.cc == cur_cc)
                                x_out_valid <= 1'b1;
                        regex_pkg::SPLIT:
                        begin
                            x_out_valid <= 1'b1;
                            y_out_valid <= 1'b1;
                        end
                        regex_pkg::JUMP:
                            x_out_valid <= 1'b1;
                        default:
                            bb_accepts <= 1'b1;
                    endcase
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // output payload, loaded while both outputs are empty
    always_ff @(posedge clk)
    begin
        if (state == S_DATA)
        begin
            // a matched character moves the thread to the next character
            x_out_data.parity <= (instr.ch.op == regex_pkg::MATCH_CHAR) ?
                                 !cur_tok.parity : cur_tok.parity;
            x_out_data.pc     <= (instr.tgt.op == regex_pkg::JUMP) ?
                                 instr.tgt.target : cur_tok.pc + 1'b1;
            y_out_data.parity <= cur_tok.parity;
            y_out_data.pc     <= instr.tgt.target;
        end
    end

    assign bb_running = has_cur || (state != S_IDLE) || x_out_valid || y_out_valid;

    // a push lands in an empty slot, so the occupancy grows by one
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !pop) |=> ($countones(slot_valid) == $past($countones(slot_valid)) + 1));

    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)));

endmodule

`default_nettype wire

// ==== instr_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "regex_cfg.svh"

module instr_memory (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             wr_en,
    input  wire [`REGEX_MEM_ADDR_WIDTH-1:0] wr_addr,
    input  wire [`REGEX_MEM_WIDTH-1:0]      wr_data,
    input  wire                             rd_valid,
    input  wire [`REGEX_MEM_ADDR_WIDTH-1:0] rd_addr,
    output logic                            rd_ready,
    output logic [`REGEX_MEM_WIDTH-1:0]     rd_data
);

    localparam int WORDS = 1 << `REGEX_MEM_ADDR_WIDTH;

    logic [`REGEX_MEM_WIDTH-1:0] mem [WORDS];

    // ready from the first cycle after reset onwards
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_ready <= 1'b0;
        else
            rd_ready <= 1'b1;
    end

    // same-address read in the write cycle sees the old word
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_valid && rd_ready)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== arbiter_rr_n.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter_rr_n #(
    parameter int N      = 5,
    parameter int DWIDTH = 8
)(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid [N],
    input  wire  [DWIDTH-1:0]   in_data  [N],
    output logic                in_ready [N],
    output logic                out_valid,
    output logic [DWIDTH-1:0]   out_data,
    input  wire                 out_ready
);

    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] sel;

    // first valid input at or after the pointer
    always_comb
    begin
        int idx;
        out_valid = 1'b0;
        sel       = '0;
        for (int i = 0; i < N; i++)
        begin
            idx = (int'(ptr) + i) % N;
            if (!out_valid && in_valid[idx])
            begin
                out_valid = 1'b1;
                sel       = PTR_W'(idx);
            end
        end
        out_data = in_data[sel];
    end

    // ready only to the winner, and only when the memory takes it
    always_comb
    begin
        for (int i = 0; i < N; i++)
        begin
            in_ready[i] = out_valid && out_ready && (sel == PTR_W'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ptr <= '0;
        else if (out_valid && out_ready)
            ptr <= (int'(sel) == N - 1) ? '0 : sel + 1'b1;
    end

    a_ptr_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(ptr) < N);

endmodule

`default_nettype wire

// ==== arbiter_2_fixed.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter_2_fixed (
    input  wire                     in_0_valid,
    input  wire regex_pkg::token_t  in_0_data,
    output logic                    in_0_ready,
    input  wire                     in_1_valid,
    input  wire regex_pkg::token_t  in_1_data,
    output logic                    in_1_ready,
    output logic                    out_valid,
    output regex_pkg::token_t       out_data,
    input  wire                     out_ready
);

    // input 0 always wins
    assign out_valid  = in_0_valid || in_1_valid;
    assign out_data   = in_0_valid ? in_0_data : in_1_data;
    assign in_0_ready = out_ready && in_0_valid;
    assign in_1_ready = out_ready && !in_0_valid;

endmodule

`default_nettype wire

// ==== regex_pkg.sv ====
`default_nettype none
`include "regex_cfg.svh"

package regex_pkg;

    // one NFA thread, parity says which character it waits for
    typedef struct packed {
        logic                       parity;
        logic [`REGEX_PC_WIDTH-1:0] pc;
    } token_t;

    typedef enum logic [1:0] {
        MATCH_CHAR = 2'd0,
        SPLIT      = 2'd1,
        JUMP       = 2'd2,
        ACCEPT     = 2'd3
    } opcode_e;

    localparam int RSVD_WIDTH = `REGEX_MEM_WIDTH - 2 - `REGEX_CHAR_WIDTH;

    typedef struct packed {
        opcode_e                      op;
        logic [RSVD_WIDTH-1:0]        rsvd;
        logic [`REGEX_CHAR_WIDTH-1:0] cc;
    } instr_char_t;

    typedef struct packed {
        opcode_e                    op;
        logic [RSVD_WIDTH-1:0]      rsvd;
        logic [`REGEX_PC_WIDTH-1:0] target;
    } instr_target_t;

    // same word, decoded by opcode
    typedef union packed {
        instr_char_t   ch;
        instr_target_t tgt;
    } instr_u;

endpackage

`default_nettype wire

// ==== regex_cfg.svh ====
`ifndef REGEX_CFG_SVH
`define REGEX_CFG_SVH

// mesh dimensions
`define REGEX_BB_N_X            2
`define REGEX_BB_N_Y            2

// thread and character widths
`define REGEX_PC_WIDTH          8
`define REGEX_CHAR_WIDTH        8

// program memory
`define REGEX_MEM_WIDTH         16
`define REGEX_MEM_ADDR_WIDTH    8

// station queue holds 2**bits tokens
`define REGEX_FIFO_DEPTH_BITS   3

`endif
